// File: core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path and register naming widths.
`define XLEN 32
`define TAG_WIDTH 6
`define NUM_PREGS 64
`define IMM_WIDTH 32

// one quotient bit per iteration.
`define DIV_STEPS `XLEN

`endif

// File: CorePkg.sv
`default_nettype none

`include "core_defs.svh"

package CorePkg;

typedef logic [`XLEN-1:0] Word;
typedef logic [`TAG_WIDTH-1:0] Tag;
typedef logic [`IMM_WIDTH-1:0] Imm;

typedef enum logic [0:0] {
    FU_INT,
    FU_DIV
} FuType;

typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLTU,
    OP_LI, // result is the immediate.
    OP_DIVU,
    OP_REMU
} OpCode;

typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} DivState;

endpackage

`default_nettype wire

// File: RegFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module RegFile
(
    input wire clk,

    input logic wen,
    input CorePkg::Tag waddr,
    input CorePkg::Word wdata,

    input CorePkg::Tag raddrA,
    input CorePkg::Tag raddrB,
    output CorePkg::Word rdataA,
    output CorePkg::Word rdataB
);

    import CorePkg::*;

    Word regs [`NUM_PREGS];

    always_ff @(posedge clk) begin
        if (wen) regs[waddr] <= wdata;
    end

    // same-cycle writes are covered by the bypass in the read stage.
    assign rdataA = regs[raddrA];
    assign rdataB = regs[raddrB];

endmodule

`default_nettype wire

// File: OperandRead.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module OperandRead
(
    input wire clk,
    input wire rst,

    input logic issueValid,
    input CorePkg::FuType issueFu,
    input CorePkg::OpCode issueOp,
    input CorePkg::Tag issueSrcA,
    input CorePkg::Tag issueSrcB,
    input CorePkg::Tag issueDst,
    input CorePkg::Imm issueImm,

    output CorePkg::Tag rfAddrA,
    output CorePkg::Tag rfAddrB,
    input CorePkg::Word rfDataA,
    input CorePkg::Word rfDataB,

    input logic wbValid,
    input CorePkg::Tag wbDst,
    input CorePkg::Word wbResult,

    output logic rdValid,
    output CorePkg::FuType rdFu,
    output CorePkg::OpCode rdOp,
    output CorePkg::Tag rdDst,
    output CorePkg::Imm rdImm,
    output CorePkg::Word rdA,
    output CorePkg::Word rdB
);

    import CorePkg::*;

    Tag srcA;
    Tag srcB;

    always_ff @(posedge clk) begin
        if (rst) rdValid <= 1'b0;
        else rdValid <= issueValid;
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            rdFu <= issueFu;
            rdOp <= issueOp;
            srcA <= issueSrcA;
            srcB <= issueSrcB;
            rdDst <= issueDst;
            rdImm <= issueImm;
        end
    end

    assign rfAddrA = srcA;
    assign rfAddrB = srcB;

    // result being written this cycle is not yet in the register file.
    assign rdA = (wbValid && wbDst == srcA) ? wbResult : rfDataA;
    assign rdB = (wbValid && wbDst == srcB) ? wbResult : rfDataB;

endmodule

`default_nettype wire

// File: IntAlu.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module IntAlu
(
    input wire clk,
    input wire rst,

    input logic rdValid,
    input CorePkg::FuType rdFu,
    input CorePkg::OpCode rdOp,
    input CorePkg::Tag rdDst,
    input CorePkg::Imm rdImm,
    input CorePkg::Word rdA,
    input CorePkg::Word rdB,

    output logic aluValid,
    output CorePkg::Tag aluDst,
    output CorePkg::Word aluResult
);

    import CorePkg::*;

    Word result;
    logic take;

    assign take = rdValid && rdFu == FU_INT;

    always_comb begin
        case (rdOp)
            OP_ADD: result = rdA + rdB;
            OP_SUB: result = rdA - rdB;
            OP_AND: result = rdA & rdB;
            OP_OR: result = rdA | rdB;
            OP_XOR: result = rdA ^ rdB;
            OP_SLTU: result = Word'(rdA < rdB);
            OP_LI: result = Word'(rdImm);
            default: result = '0; // divider ops never reach here.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) aluValid <= 1'b0;
        else aluValid <= take;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            aluDst <= rdDst;
            aluResult <= result;
        end
    end

endmodule

`default_nettype wire

// File: Divide.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module Divide
(
    input wire clk,
    input wire rst,

    input logic rdValid,
    input CorePkg::FuType rdFu,
    input CorePkg::OpCode rdOp,
    input CorePkg::Tag rdDst,
    input CorePkg::Word rdA,
    input CorePkg::Word rdB,

    input logic divGrant,

    output logic divBusy,
    output logic divReady,
    output CorePkg::Tag divDst,
    output CorePkg::Word divResult
);

    import CorePkg::*;

    DivState state;
    Word divisor;
    Word rem;
    Word quot; // holds the dividend bits not yet shifted out.
    logic isRem;
    logic [$clog2(`DIV_STEPS)-1:0] stepCnt;

    logic start;
    logic lastStep;
    logic fits;
    logic [`XLEN:0] remShift;
    logic [`XLEN:0] diff;

    assign start = state == DIV_IDLE && rdValid && rdFu == FU_DIV;
    assign lastStep = stepCnt == ($clog2(`DIV_STEPS))'(`DIV_STEPS - 1);

    assign remShift = {rem, quot[`XLEN-1]};
    assign diff = remShift - {1'b0, divisor};
    assign fits = remShift >= {1'b0, divisor}; // always true for a zero divisor.

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DIV_IDLE;
        end else begin
            case (state)
                DIV_IDLE: if (start) state <= DIV_RUN;
                DIV_RUN: if (lastStep) state <= DIV_DONE;
                DIV_DONE: if (divGrant) state <= DIV_IDLE;
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem <= '0;
            quot <= rdA;
            divisor <= rdB;
            isRem <= rdOp == OP_REMU;
            divDst <= rdDst;
            stepCnt <= '0;
        end else if (state == DIV_RUN) begin
            rem <= fits ? diff[`XLEN-1:0] : remShift[`XLEN-1:0];
            quot <= {quot[`XLEN-2:0], fits};
            stepCnt <= stepCnt + 1'b1;
        end
    end

    // divide by zero leaves all ones in quot and the dividend in rem.
    assign divResult = isRem ? rem : quot;
    assign divReady = state == DIV_DONE;
    assign divBusy = state != DIV_IDLE;

endmodule

`default_nettype wire

// File: ExecPort.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module ExecPort
(
    input wire clk,
    input wire rst,

    input logic issueValid,
    input CorePkg::FuType issueFu,
    input CorePkg::OpCode issueOp,
    input CorePkg::Tag issueSrcA,
    input CorePkg::Tag issueSrcB,
    input CorePkg::Tag issueDst,
    input CorePkg::Imm issueImm,

    output logic divNoIssue,

    output logic wbValid,
    output CorePkg::Tag wbDst,
    output CorePkg::Word wbResult
);

    import CorePkg::*;

    Tag rfAddrA;
    Tag rfAddrB;
    Word rfDataA;
    Word rfDataB;

    logic rdValid;
    FuType rdFu;
    OpCode rdOp;
    Tag rdDst;
    Imm rdImm;
    Word rdA;
    Word rdB;

    logic aluValid;
    Tag aluDst;
    Word aluResult;

    logic divBusy;
    logic divReady;
    logic divGrant;
    Tag divDst;
    Word divResult;

    RegFile rf
    (
        .clk(clk),
        .wen(wbValid), .waddr(wbDst), .wdata(wbResult),
        .raddrA(rfAddrA), .rdataA(rfDataA),
        .raddrB(rfAddrB), .rdataB(rfDataB)
    );

    OperandRead opRead
    (
        .clk(clk), .rst(rst),
        .issueValid(issueValid), .issueFu(issueFu), .issueOp(issueOp),
        .issueSrcA(issueSrcA), .issueSrcB(issueSrcB),
        .issueDst(issueDst), .issueImm(issueImm),
        .rfAddrA(rfAddrA), .rfAddrB(rfAddrB), .rfDataA(rfDataA), .rfDataB(rfDataB),
        .wbValid(wbValid), .wbDst(wbDst), .wbResult(wbResult),
        .rdValid(rdValid), .rdFu(rdFu), .rdOp(rdOp), .rdDst(rdDst),
        .rdImm(rdImm), .rdA(rdA), .rdB(rdB)
    );

    IntAlu ialu
    (
        .clk(clk), .rst(rst),
        .rdValid(rdValid), .rdFu(rdFu), .rdOp(rdOp), .rdDst(rdDst),
        .rdImm(rdImm), .rdA(rdA), .rdB(rdB),
        .aluValid(aluValid), .aluDst(aluDst), .aluResult(aluResult)
    );

    Divide div
    (
        .clk(clk), .rst(rst),
        .rdValid(rdValid), .rdFu(rdFu), .rdOp(rdOp), .rdDst(rdDst),
        .rdA(rdA), .rdB(rdB),
        .divGrant(divGrant),
        .divBusy(divBusy), .divReady(divReady), .divDst(divDst), .divResult(divResult)
    );

    // alu has fixed priority, divider waits for a free slot.
    assign divGrant = divReady && !aluValid;
    assign wbValid = aluValid || divReady;
    assign wbDst = aluValid ? aluDst : divDst;
    assign wbResult = aluValid ? aluResult : divResult;

    assign divNoIssue = divBusy || (rdValid && rdFu == FU_DIV) ||
        (issueValid && issueFu == FU_DIV);

endmodule

`default_nettype wire

// File: ExecPort_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module ExecPort_tb;

    import CorePkg::*;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic issueValid = 1'b0;
    FuType issueFu = FU_INT;
    OpCode issueOp = OP_ADD;
    Tag issueSrcA = '0;
    Tag issueSrcB = '0;
    Tag issueDst = '0;
    Imm issueImm = '0;
    logic divNoIssue;
    logic wbValid;
    Tag wbDst;
    Word wbResult;

    Word model [`NUM_PREGS];
    logic intNext = 1'b0;
    logic pipe1Valid = 1'b0;
    logic pipe2Valid = 1'b0;
    Tag intNextDst;
    Tag pipe1Dst;
    Tag pipe2Dst;
    Word intNextRes;
    Word pipe1Res;
    Word pipe2Res;
    Tag divQDst [$];
    Word divQRes [$];
    logic divHeadValid = 1'b0;
    Tag divHeadDst;
    Word divHeadRes;
    int errCount = 0;
    int errAtStart = 0;
    int testCount = 0;
    int failCount = 0;

    ExecPort UUT (
        .clk(clk), .rst(rst),
        .issueValid(issueValid), .issueFu(issueFu), .issueOp(issueOp),
        .issueSrcA(issueSrcA), .issueSrcB(issueSrcB), .issueDst(issueDst), .issueImm(issueImm),
        .divNoIssue(divNoIssue), .wbValid(wbValid), .wbDst(wbDst), .wbResult(wbResult)
    );

    always #4 clk = ~clk;

    function automatic Word modelResult(input OpCode op, input Word a, input Word b, input Imm imm);
        case (op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_OR: return a | b;
            OP_XOR: return a ^ b;
            OP_SLTU: return (a < b) ? Word'(1) : Word'(0);
            OP_LI: return Word'(imm);
            OP_DIVU: return (b == 0) ? '1 : a / b; // riscv rule for a zero divisor.
            OP_REMU: return (b == 0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    function automatic Tag randTag(input int top);
        return Tag'($urandom_range(top, 0));
    endfunction

    task automatic refreshHead();
        divHeadValid = divQDst.size() > 0;
        if (divHeadValid) begin
            divHeadDst = divQDst[0];
            divHeadRes = divQRes[0];
        end
    endtask

    // integer results land two cycles after issue, divides leave in order.
    always @(posedge clk) begin
        pipe1Valid <= intNext;
        pipe1Dst <= intNextDst;
        pipe1Res <= intNextRes;
        pipe2Valid <= pipe1Valid;
        pipe2Dst <= pipe1Dst;
        pipe2Res <= pipe1Res;
        if (!rst && wbValid && !pipe2Valid && divQDst.size() > 0) begin
            void'(divQDst.pop_front());
            void'(divQRes.pop_front());
            refreshHead();
        end
    end

    aIntValid: assert property (@(negedge clk) disable iff (rst) pipe2Valid |-> wbValid)
        else begin
            $display("Mismatch wbValid: expected 1, got %h", wbValid);
            errCount++;
        end
    aIntDst: assert property (@(negedge clk) disable iff (rst) pipe2Valid |-> wbDst == pipe2Dst)
        else begin
            $display("Mismatch wbDst: expected %h, got %h", pipe2Dst, wbDst);
            errCount++;
        end
    aIntRes: assert property (@(negedge clk) disable iff (rst)
        pipe2Valid |-> wbResult == pipe2Res)
        else begin
            $display("Mismatch wbResult: expected %h, got %h", pipe2Res, wbResult);
            errCount++;
        end
    aWbQuiet: assert property (@(negedge clk) disable iff (rst)
        !pipe2Valid && !divHeadValid |-> !wbValid)
        else begin
            $display("Mismatch wbValid: expected 0, got %h", wbValid);
            errCount++;
        end
    aDivDst: assert property (@(negedge clk) disable iff (rst)
        wbValid && !pipe2Valid && divHeadValid |-> wbDst == divHeadDst)
        else begin
            $display("Mismatch wbDst: expected %h, got %h", divHeadDst, wbDst);
            errCount++;
        end
    aDivRes: assert property (@(negedge clk) disable iff (rst)
        wbValid && !pipe2Valid && divHeadValid |-> wbResult == divHeadRes)
        else begin
            $display("Mismatch wbResult: expected %h, got %h", divHeadRes, wbResult);
            errCount++;
        end
    aNoIssue: assert property (@(negedge clk) disable iff (rst) divNoIssue == divHeadValid)
        else begin
            $display("Mismatch divNoIssue: expected %h, got %h", divHeadValid, divNoIssue);
            errCount++;
        end

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic issue(input FuType fu, input OpCode op, input Tag a, input Tag b,
                         input Tag dst, input Imm imm);
        Word res;
        res = modelResult(op, model[a], model[b], imm);
        model[dst] = res;
        issueValid = 1'b1;
        issueFu = fu;
        issueOp = op;
        issueSrcA = a;
        issueSrcB = b;
        issueDst = dst;
        issueImm = imm;
        if (fu == FU_INT) begin
            intNext = 1'b1;
            intNextDst = dst;
            intNextRes = res;
        end else begin
            divQDst.push_back(dst);
            divQRes.push_back(res);
            refreshHead();
        end
        idle(1);
        issueValid = 1'b0;
        intNext = 1'b0;
    endtask

    task automatic issueDiv(input OpCode op, input Tag a, input Tag b, input Tag dst);
        int waited;
        waited = 0;
        while (divNoIssue && waited < 100) begin
            idle(1);
            waited++;
        end
        if (divNoIssue) begin
            $display("timeout waiting for divNoIssue to fall");
            errCount++;
        end else begin
            issue(FU_DIV, op, a, b, dst, '0);
        end
    endtask

    task automatic waitDrain(input int limit);
        int waited;
        waited = 0;
        while (divQDst.size() > 0 && waited < limit) begin
            idle(1);
            waited++;
        end
        if (divQDst.size() > 0) begin
            $display("timeout waiting for a divide to write back");
            errCount++;
        end
    endtask

    task automatic randomOps(input int count, input int maxTag, input int idlePct);
        for (int i = 0; i < count; i++) begin
            if ($urandom_range(99, 0) < idlePct) idle(1);
            else issue(FU_INT, OpCode'($urandom_range(6, 0)), randTag(maxTag), randTag(maxTag),
                       randTag(maxTag), $urandom);
        end
    endtask

    task automatic endTest(input string name);
        idle(4); // let results in flight reach writeback.
        testCount++;
        if (errCount == errAtStart) begin
            $display("%s: ok", name);
        end else begin
            failCount++;
            $display("%s: %0d errors", name, errCount - errAtStart);
        end
        errAtStart = errCount;
    endtask

    initial begin
        Tag prev;
        Tag dst;
        Word a;
        Word b;
        void'($urandom(32'hc2fd_9c92));
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        idle(6);
        endTest("reset quiet");

        for (int t = 0; t < `NUM_PREGS; t++) issue(FU_INT, OP_LI, '0, '0, Tag'(t), $urandom);
        randomOps(200, `NUM_PREGS - 1, 0);
        endTest("random integer ops");

        prev = randTag(`NUM_PREGS - 1);
        for (int i = 0; i < 24; i++) begin
            dst = randTag(`NUM_PREGS - 1);
            issue(FU_INT, OpCode'($urandom_range(5, 0)), prev, randTag(`NUM_PREGS - 1), dst, '0);
            prev = dst;
        end
        endTest("bypass chain");

        for (int k = 0; k < 10; k++) begin
            a = (k == 1 || k == 2) ? '0 : $urandom;
            b = (k == 0 || k == 3) ? '0 : $urandom >> $urandom_range(28, 0);
            issue(FU_INT, OP_LI, '0, '0, 1, a);
            issue(FU_INT, OP_LI, '0, '0, 2, b);
            issueDiv(k % 2 ? OP_REMU : OP_DIVU, 1, 2, 3);
            waitDrain(100);
        end
        endTest("divide and remainder");

        // traffic stays below tag 60 so the divide owns its tags.
        repeat (3) begin
            issue(FU_INT, OP_LI, '0, '0, 61, $urandom);
            issue(FU_INT, OP_LI, '0, '0, 62, $urandom >> $urandom_range(20, 0));
            issueDiv($urandom_range(1, 0) ? OP_REMU : OP_DIVU, 61, 62, 60);
            randomOps(60, 59, 25);
            waitDrain(200);
        end
        endTest("divide under traffic");

        issue(FU_INT, OP_LI, '0, '0, 61, $urandom);
        issue(FU_INT, OP_LI, '0, '0, 62, $urandom >> 8);
        issueDiv(OP_DIVU, 61, 62, 63);
        idle(`DIV_STEPS);
        issue(FU_INT, OP_ADD, 63, 0, 10, '0); // read stage meets the divide writeback.
        waitDrain(100);
        idle(2);
        issue(FU_INT, OP_XOR, 63, 10, 11, '0);
        endTest("divide result reuse");

        $display("tests %0d, failed %0d, errors %0d", testCount, failCount, errCount);
        if (errCount == 0) $display("Result: PASSED");
        else $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
CorePkg.sv
RegFile.sv
OperandRead.sv
IntAlu.sv
Divide.sv
ExecPort.sv
ExecPort_tb.sv

// File: Bender.yml
package:
  name: exec_port

export_include_dirs:
  - .

sources:
  - CorePkg.sv
  - RegFile.sv
  - OperandRead.sv
  - IntAlu.sv
  - Divide.sv
  - ExecPort.sv
  - target: test
    files:
      - ExecPort_tb.sv
